//--- hdl/cfg_loader_pkg.sv
// ------------------------------------------------
// Shared widths, sizes, register map and types for
// the configuration loader. Every RTL file imports
// this package; the testbench uses it as well.
// ------------------------------------------------

package cfg_loader_pkg;

  localparam int NUM_TILES   = 2;
  localparam int UCODE_ELS   = 8;
  localparam int MAX_CREDITS = 4;
  localparam int SYNC_CYCLES = 16;              // quiet wait after the cce mode writes

  typedef logic [63:0] dword_t;
  typedef logic [15:0] reg_addr_t;
  typedef logic [3:0]  tile_id_t;
  typedef logic [7:0]  lce_id_t;
  typedef logic [2:0]  credit_t;
  typedef logic [2:0]  ucode_idx_t;
  typedef logic [3:0]  msg_type_t;
  typedef logic [2:0]  msg_size_t;
  typedef logic [3:0]  dev_id_t;
  typedef logic [$clog2(SYNC_CYCLES)-1:0] sync_cnt_t;

  localparam reg_addr_t REG_FREEZE      = 16'h0008;
  localparam reg_addr_t REG_ICACHE_MODE = 16'h0010;
  localparam reg_addr_t REG_DCACHE_MODE = 16'h0018;
  localparam reg_addr_t REG_CCE_MODE    = 16'h0020;
  localparam reg_addr_t REG_HIO_MASK    = 16'h0028;
  localparam reg_addr_t UCODE_BASE      = 16'h8000;

  localparam dword_t    HIO_MASK    = 64'h0000_0000_0000_0001;  // enables host io 0 only
  localparam dword_t    MODE_NORMAL = 64'd1;
  localparam dev_id_t   CFG_DEV     = 4'd2;
  localparam msg_type_t MSG_UC_WR   = 4'd1;
  localparam msg_size_t MSG_SIZE_8  = 3'd3;

  typedef enum logic [3:0] {
    RESET,
    FREEZE_SET,
    SEND_UCODE,
    SEND_ICACHE,
    SEND_DCACHE,
    SEND_CCE,
    WAIT_SYNC,
    SEND_HIO,
    FREEZE_CLR,
    WAIT_CREDITS,
    DONE
  } cfg_state_e;

  typedef enum logic [2:0] {
    SEL_FREEZE_ON,
    SEL_UCODE,
    SEL_ICACHE,
    SEL_DCACHE,
    SEL_CCE,
    SEL_HIO,
    SEL_FREEZE_OFF
  } reg_sel_e;

  typedef struct packed {
    msg_type_t msg_type;
    msg_size_t size;
    lce_id_t   lce_id;
    tile_id_t  tile;
    dev_id_t   dev;
    reg_addr_t addr;
  } cfg_fwd_header_t;

endpackage

//--- hdl/cfg_loader_ctrl.sv
// ------------------------------------------------
// Boot sequence FSM. Walks freeze, microcode, mode,
// quiet wait, host io and unfreeze over all tiles,
// advancing one command per accept, then waits for
// every credit to come back and raises done.
// ------------------------------------------------

`timescale 1ns/10ps

module cfg_loader_ctrl (
  input  logic                       clk_i,
  input  logic                       reset_i,
  input  logic                       accept_i,
  input  logic                       credits_empty_i,
  output logic                       cmd_v_o,
  output cfg_loader_pkg::reg_sel_e   sel_o,
  output cfg_loader_pkg::tile_id_t   tile_o,
  output cfg_loader_pkg::ucode_idx_t ucode_idx_o,
  output logic                       done_o
);
  import cfg_loader_pkg::*;

  cfg_state_e state_r;
  cfg_state_e state_n;
  cfg_state_e sweep_next;
  tile_id_t   tile_r;
  tile_id_t   tile_n;
  ucode_idx_t ucode_idx_r;
  ucode_idx_t ucode_idx_n;
  sync_cnt_t  sync_cnt_r;
  sync_cnt_t  sync_cnt_n;
  logic       tile_adv;
  logic       last_tile;
  logic       last_idx;
  logic       sync_done;

  assign last_tile = (tile_r == tile_id_t'(NUM_TILES - 1));
  assign last_idx  = (ucode_idx_r == ucode_idx_t'(UCODE_ELS - 1));
  assign sync_done = (sync_cnt_r == sync_cnt_t'(SYNC_CYCLES - 1));

  always_comb begin
    state_n     = state_r;
    tile_n      = tile_r;
    ucode_idx_n = ucode_idx_r;
    sync_cnt_n  = sync_cnt_r;
    sweep_next  = state_r;
    tile_adv    = 1'b0;
    cmd_v_o     = 1'b0;
    sel_o       = SEL_FREEZE_ON;

    case (state_r)
      RESET: begin
        state_n = FREEZE_SET;
      end
      FREEZE_SET: begin
        cmd_v_o    = 1'b1;
        sel_o      = SEL_FREEZE_ON;
        tile_adv   = accept_i;
        sweep_next = SEND_UCODE;
      end
      SEND_UCODE: begin
        cmd_v_o    = 1'b1;
        sel_o      = SEL_UCODE;
        sweep_next = SEND_ICACHE;
        if (accept_i) begin
          ucode_idx_n = last_idx ? '0 : ucode_idx_r + 1'b1;
          tile_adv    = last_idx;              // next tile once its whole image is out
        end
      end
      SEND_ICACHE: begin
        cmd_v_o    = 1'b1;
        sel_o      = SEL_ICACHE;
        tile_adv   = accept_i;
        sweep_next = SEND_DCACHE;
      end
      SEND_DCACHE: begin
        cmd_v_o    = 1'b1;
        sel_o      = SEL_DCACHE;
        tile_adv   = accept_i;
        sweep_next = SEND_CCE;
      end
      SEND_CCE: begin
        cmd_v_o    = credits_empty_i;          // earlier writes must land before cce goes live
        sel_o      = SEL_CCE;
        tile_adv   = accept_i;
        sweep_next = WAIT_SYNC;
      end
      WAIT_SYNC: begin
        sync_cnt_n = sync_done ? '0 : sync_cnt_r + 1'b1;
        if (sync_done) begin
          state_n = SEND_HIO;
        end
      end
      SEND_HIO: begin
        cmd_v_o    = credits_empty_i;
        sel_o      = SEL_HIO;
        tile_adv   = accept_i;
        sweep_next = FREEZE_CLR;
      end
      FREEZE_CLR: begin
        cmd_v_o    = 1'b1;
        sel_o      = SEL_FREEZE_OFF;
        tile_adv   = accept_i;
        sweep_next = WAIT_CREDITS;
      end
      WAIT_CREDITS: begin
        if (credits_empty_i) begin
          state_n = DONE;
        end
      end
      DONE: begin
        state_n = DONE;
      end
      default: begin
        state_n = RESET;
      end
    endcase

    if (tile_adv) begin
      tile_n = last_tile ? '0 : tile_r + 1'b1;
      if (last_tile) begin
        state_n = sweep_next;                  // sweep over all tiles finished
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_r     <= RESET;
      tile_r      <= '0;
      ucode_idx_r <= '0;
      sync_cnt_r  <= '0;
    end else begin
      state_r     <= state_n;
      tile_r      <= tile_n;
      ucode_idx_r <= ucode_idx_n;
      sync_cnt_r  <= sync_cnt_n;
    end
  end

  assign tile_o      = tile_r;
  assign ucode_idx_o = ucode_idx_r;
  assign done_o      = (state_r == DONE);

  // a stalled command must be offered again unchanged
  a_hold_cmd: assert property (@(posedge clk_i) disable iff (reset_i)
    (cmd_v_o && !accept_i) |=> ($stable(sel_o) && $stable(tile_o) && $stable(ucode_idx_o)));

endmodule

//--- hdl/cfg_credit_counter.sv
// ------------------------------------------------
// Outstanding command counter. Counts up on every
// accepted command, down on every return pulse,
// and flags when the credit limit is reached.
// ------------------------------------------------

`timescale 1ns/10ps

module cfg_credit_counter (
  input  logic                    clk_i,
  input  logic                    reset_i,
  input  logic                    inc_i,
  input  logic                    dec_i,
  output cfg_loader_pkg::credit_t count_o,
  output logic                    full_o,
  output logic                    empty_o
);
  import cfg_loader_pkg::*;

  credit_t count_r;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      count_r <= '0;
    end else if (inc_i && !dec_i) begin
      count_r <= count_r + 1'b1;
    end else if (dec_i && !inc_i) begin
      count_r <= count_r - 1'b1;
    end
  end

  assign count_o = count_r;
  assign full_o  = (count_r == credit_t'(MAX_CREDITS));
  assign empty_o = (count_r == '0);

  // the top gates valid on full, so an accept can never overflow
  a_no_overflow: assert property (@(posedge clk_i) disable iff (reset_i)
    inc_i |-> !full_o);

  // a return without a command in flight means the endpoint misbehaved
  a_no_underflow: assert property (@(posedge clk_i) disable iff (reset_i)
    dec_i |-> !empty_o);

endmodule

//--- hdl/cfg_ucode_rom.sv
// ------------------------------------------------
// Coherence engine microcode image, loaded from
// ucode.mem as binary text, read combinationally
// by word index.
// ------------------------------------------------

`timescale 1ns/10ps

module cfg_ucode_rom (
  input  logic                       clk_i,
  input  cfg_loader_pkg::ucode_idx_t idx_i,
  output cfg_loader_pkg::dword_t     word_o
);
  import cfg_loader_pkg::*;

  dword_t          rom_mem [0:UCODE_ELS-1];
  bit     [63:0]   word_2s;                    // two-state so a short image reads as zero

  initial begin
    $readmemb("ucode.mem", rom_mem);
  end

  assign word_2s = rom_mem[idx_i];
  assign word_o  = word_2s;

  // every word the sequence sends should come from the image file
  a_word_loaded: assert property (@(posedge clk_i)
    !$isunknown(idx_i) |-> !$isunknown(rom_mem[idx_i]));

endmodule

//--- hdl/cfg_cmd_former.sv
// ------------------------------------------------
// Forward command former. Turns the register
// select, tile and microcode word into the
// uncached 8-byte write header and its data.
// ------------------------------------------------

`timescale 1ns/10ps

module cfg_cmd_former (
  input  cfg_loader_pkg::reg_sel_e        sel_i,
  input  cfg_loader_pkg::tile_id_t        tile_i,
  input  cfg_loader_pkg::ucode_idx_t      ucode_idx_i,
  input  cfg_loader_pkg::dword_t          ucode_word_i,
  input  cfg_loader_pkg::lce_id_t         lce_id_i,
  output cfg_loader_pkg::cfg_fwd_header_t header_o,
  output cfg_loader_pkg::dword_t          data_o
);
  import cfg_loader_pkg::*;

  reg_addr_t addr;

  always_comb begin
    addr   = REG_FREEZE;
    data_o = '0;
    case (sel_i)
      SEL_FREEZE_ON: begin
        addr   = REG_FREEZE;
        data_o = dword_t'(1);
      end
      SEL_UCODE: begin
        addr   = UCODE_BASE + reg_addr_t'({ucode_idx_i, 3'b000});  // one dword per word
        data_o = ucode_word_i;
      end
      SEL_ICACHE: begin
        addr   = REG_ICACHE_MODE;
        data_o = MODE_NORMAL;
      end
      SEL_DCACHE: begin
        addr   = REG_DCACHE_MODE;
        data_o = MODE_NORMAL;
      end
      SEL_CCE: begin
        addr   = REG_CCE_MODE;
        data_o = MODE_NORMAL;
      end
      SEL_HIO: begin
        addr   = REG_HIO_MASK;
        data_o = HIO_MASK;
      end
      default: begin
        addr   = REG_FREEZE;                   // freeze off writes zero
        data_o = '0;
      end
    endcase
  end

  assign header_o.msg_type = MSG_UC_WR;
  assign header_o.size     = MSG_SIZE_8;
  assign header_o.lce_id   = lce_id_i;
  assign header_o.tile     = tile_i;
  assign header_o.dev      = CFG_DEV;
  assign header_o.addr     = addr;

endmodule

//--- hdl/cfg_loader_top.sv
// ------------------------------------------------
// Configuration loader top. Drives the boot writes
// onto the IO forward stream with a valid/yumi
// handshake and counts return pulses as credits.
// ------------------------------------------------

`timescale 1ns/10ps

module cfg_loader_top (
  input  logic                            clk_i,
  input  logic                            reset_i,
  input  cfg_loader_pkg::lce_id_t         lce_id_i,
  output cfg_loader_pkg::cfg_fwd_header_t fwd_header_o,
  output cfg_loader_pkg::dword_t          fwd_data_o,
  output logic                            fwd_v_o,
  output logic                            fwd_last_o,
  input  logic                            fwd_yumi_i,
  input  logic                            rev_v_i,
  output logic                            done_o
);
  import cfg_loader_pkg::*;

  logic       cmd_v;
  logic       accept;
  logic       credits_full;
  logic       credits_empty;
  reg_sel_e   sel;
  tile_id_t   tile;
  ucode_idx_t ucode_idx;
  dword_t     ucode_word;

  assign fwd_v_o    = cmd_v & ~credits_full;   // hold off while the credit limit is reached
  assign accept     = fwd_v_o & fwd_yumi_i;
  assign fwd_last_o = 1'b1;

  cfg_loader_ctrl u_ctrl (
    .clk_i(clk_i), .reset_i(reset_i), .accept_i(accept), .credits_empty_i(credits_empty),
    .cmd_v_o(cmd_v), .sel_o(sel), .tile_o(tile), .ucode_idx_o(ucode_idx), .done_o(done_o)
  );

  cfg_credit_counter u_credits (
    .clk_i(clk_i), .reset_i(reset_i), .inc_i(accept), .dec_i(rev_v_i),
    .count_o(), .full_o(credits_full), .empty_o(credits_empty)
  );

  cfg_ucode_rom u_rom (.clk_i(clk_i), .idx_i(ucode_idx), .word_o(ucode_word));

  cfg_cmd_former u_former (
    .sel_i(sel), .tile_i(tile), .ucode_idx_i(ucode_idx), .ucode_word_i(ucode_word),
    .lce_id_i(lce_id_i), .header_o(fwd_header_o), .data_o(fwd_data_o)
  );

endmodule

//--- test/cfg_loader_tb.sv
// ------------------------------------------------
// Testbench for the configuration loader. Plays the
// IO endpoint with seeded back-pressure and return
// delays, runs the directed tests in order and
// stops at the first mismatch.
// ------------------------------------------------

`timescale 1ns/10ps

module cfg_loader_tb;
  import cfg_loader_pkg::*;

  localparam int NUM_CMDS   = NUM_TILES * (UCODE_ELS + 6);
  localparam int MAX_DELAY  = 6;                  // longest return delay in cycles
  localparam int RUN_CYCLES = NUM_CMDS * (2 * MAX_DELAY + 4) + SYNC_CYCLES + 40;
  localparam int TIMEOUT    = 6 * RUN_CYCLES;

  logic            clk_i;
  logic            reset_i;
  lce_id_t         lce_id_i;
  cfg_fwd_header_t fwd_header_o;
  dword_t          fwd_data_o;
  logic            fwd_v_o;
  logic            fwd_last_o;
  logic            fwd_yumi_i;
  logic            rev_v_i;
  logic            done_o;

  dword_t          ucode_img [0:UCODE_ELS-1];
  reg_addr_t       exp_addr [$];
  dword_t          exp_data [$];
  tile_id_t        exp_tile [$];
  reg_addr_t       got_addr [$];
  dword_t          got_data [$];
  int              due_cycle [$];              // cycle at which each credit goes back
  int              cycle;
  int              cce_cycle;
  int              acc_count;
  int              ret_count;
  int              timeout_cnt;
  int unsigned     lcg_state;
  int              max_delay;
  bit              yumi_random;
  bit              hold_returns;
  bit              prev_stall;
  bit              seen_done;
  cfg_fwd_header_t prev_hdr;
  dword_t          prev_data;

  cfg_loader_top uut (
    .clk_i(clk_i), .reset_i(reset_i), .lce_id_i(lce_id_i), .fwd_header_o(fwd_header_o),
    .fwd_data_o(fwd_data_o), .fwd_v_o(fwd_v_o), .fwd_last_o(fwd_last_o),
    .fwd_yumi_i(fwd_yumi_i), .rev_v_i(rev_v_i), .done_o(done_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #20 clk_i = ~clk_i;
  end

  always @(posedge clk_i) begin
    timeout_cnt <= timeout_cnt + 1;
    if (timeout_cnt >= TIMEOUT) begin
      $display("timeout after %0d cycles, the tests did not finish", timeout_cnt);
      $display("TESTS FAILED");
      $fatal(1);
    end
  end

  function automatic int unsigned lcg_next();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state >> 16;
  endfunction

  task automatic stop_run(input string msg);
    $display("%s", msg);
    $display("TESTS FAILED");
    $fatal(1);
  endtask

  task automatic value_error(input string name, input logic [63:0] got, input logic [63:0] exp);
    stop_run($sformatf("FAILED at %0t: %s is %h, expected %h", $time, name, got, exp));
  endtask

  task automatic push_one(input reg_addr_t addr, input dword_t data, input int tile);
    exp_addr.push_back(addr);
    exp_data.push_back(data);
    exp_tile.push_back(tile_id_t'(tile));
  endtask

  task automatic push_sweep(input reg_addr_t addr, input dword_t data);
    for (int t = 0; t < NUM_TILES; t++) begin
      push_one(addr, data, t);
    end
  endtask

  // boot order: freeze, microcode, three modes, host io, unfreeze
  task automatic build_expected();
    push_sweep(REG_FREEZE, dword_t'(1));
    for (int t = 0; t < NUM_TILES; t++) begin
      for (int i = 0; i < UCODE_ELS; i++) begin
        push_one(UCODE_BASE + reg_addr_t'(8 * i), ucode_img[i], t);
      end
    end
    push_sweep(REG_ICACHE_MODE, MODE_NORMAL);
    push_sweep(REG_DCACHE_MODE, MODE_NORMAL);
    push_sweep(REG_CCE_MODE, MODE_NORMAL);
    push_sweep(REG_HIO_MASK, HIO_MASK);
    push_sweep(REG_FREEZE, dword_t'(0));
  endtask

  task automatic check_command();
    assert (acc_count < exp_addr.size())
      else stop_run("more commands accepted than the boot sequence holds");
    assert (fwd_header_o.msg_type == 4'd1)
      else value_error("fwd_header_o.msg_type", 64'(fwd_header_o.msg_type), 64'd1);
    assert (fwd_header_o.size == 3'd3)
      else value_error("fwd_header_o.size", 64'(fwd_header_o.size), 64'd3);
    assert (fwd_header_o.dev == CFG_DEV)
      else value_error("fwd_header_o.dev", 64'(fwd_header_o.dev), 64'(CFG_DEV));
    assert (fwd_header_o.lce_id == lce_id_i)
      else value_error("fwd_header_o.lce_id", 64'(fwd_header_o.lce_id), 64'(lce_id_i));
    assert (fwd_header_o.tile == exp_tile[acc_count])
      else value_error("fwd_header_o.tile", 64'(fwd_header_o.tile), 64'(exp_tile[acc_count]));
    assert (fwd_header_o.addr == exp_addr[acc_count])
      else value_error("fwd_header_o.addr", 64'(fwd_header_o.addr), 64'(exp_addr[acc_count]));
    assert (fwd_data_o == exp_data[acc_count])
      else value_error("fwd_data_o", fwd_data_o, exp_data[acc_count]);
    assert (fwd_last_o) else value_error("fwd_last_o", 64'(fwd_last_o), 64'd1);
    got_addr.push_back(fwd_header_o.addr);
    got_data.push_back(fwd_data_o);
  endtask

  // one endpoint cycle: check outputs, then drive yumi and the return pulse
  task automatic step_cycle();
    @(negedge clk_i);
    cycle++;
    if (prev_stall) begin
      assert (fwd_v_o) else stop_run("valid dropped while a command was waiting for yumi");
      assert (fwd_header_o == prev_hdr)
        else value_error("fwd_header_o", 64'(fwd_header_o), 64'(prev_hdr));
      assert (fwd_data_o == prev_data) else value_error("fwd_data_o", fwd_data_o, prev_data);
    end
    if (fwd_v_o) begin
      assert (acc_count - ret_count < MAX_CREDITS)
        else stop_run("command offered while every credit was in use");
      if (fwd_header_o.addr == REG_CCE_MODE || fwd_header_o.addr == REG_HIO_MASK) begin
        assert (acc_count == ret_count)
          else stop_run("cce or host io command offered with credits outstanding");
      end
      // the quiet wait starts the cycle after the last cce accept
      if (fwd_header_o.addr == REG_HIO_MASK && fwd_header_o.tile == '0 && !prev_stall) begin
        assert (cycle - cce_cycle == SYNC_CYCLES + 1)
          else value_error("cycles from cce to host io", 64'(cycle - cce_cycle),
                           64'(SYNC_CYCLES + 1));
      end
    end
    if (seen_done) begin
      assert (done_o) else stop_run("done_o fell before reset");
    end
    if (done_o) begin
      assert (acc_count == NUM_CMDS && ret_count == NUM_CMDS)
        else stop_run("done_o rose before every command was accepted and answered");
      seen_done = 1'b1;
    end
    fwd_yumi_i = yumi_random ? logic'(lcg_next() % 3 != 0) : 1'b1;
    if (fwd_v_o && fwd_yumi_i) begin
      check_command();
      if (fwd_header_o.addr == REG_CCE_MODE) begin
        cce_cycle = cycle;
      end
      due_cycle.push_back(cycle + 1 + int'(lcg_next() % (max_delay + 1)));
      acc_count++;
    end
    prev_stall = fwd_v_o && !fwd_yumi_i;
    prev_hdr   = fwd_header_o;
    prev_data  = fwd_data_o;
    rev_v_i    = 1'b0;
    if (!hold_returns && due_cycle.size() > 0 && due_cycle[0] <= cycle) begin
      rev_v_i = 1'b1;
      void'(due_cycle.pop_front());
      ret_count++;
    end
  endtask

  task automatic apply_reset();
    @(negedge clk_i);
    reset_i    = 1'b1;
    fwd_yumi_i = 1'b0;
    rev_v_i    = 1'b0;
    acc_count  = 0;
    ret_count  = 0;
    prev_stall = 1'b0;
    seen_done  = 1'b0;
    got_addr.delete();
    got_data.delete();
    due_cycle.delete();
    repeat (3) begin
      @(negedge clk_i);
      assert (!fwd_v_o) else value_error("fwd_v_o", 64'(fwd_v_o), 64'd0);
      assert (!done_o) else value_error("done_o", 64'(done_o), 64'd0);
    end
    reset_i = 1'b0;
    assert (!fwd_v_o) else value_error("fwd_v_o", 64'(fwd_v_o), 64'd0);
  endtask

  task automatic run_to_done();
    while (!seen_done) begin
      step_cycle();
    end
    assert (got_addr.size() == NUM_CMDS)
      else value_error("accepted commands", 64'(got_addr.size()), 64'(NUM_CMDS));
  endtask

  task automatic check_reset_state();
    apply_reset();
    @(negedge clk_i);
    assert (fwd_v_o) else value_error("fwd_v_o", 64'(fwd_v_o), 64'd1);  // second cycle
  endtask

  task automatic run_full_order();
    lce_id_i     = 8'h5a;
    yumi_random  = 1'b0;
    hold_returns = 1'b0;
    max_delay    = 1;
    apply_reset();
    run_to_done();
  endtask

  task automatic check_ucode_contents();
    int idx;
    int n;
    n = 0;
    foreach (got_addr[k]) begin
      if (got_addr[k] >= UCODE_BASE) begin
        idx = int'((got_addr[k] - UCODE_BASE) >> 3);
        assert (idx < UCODE_ELS) else stop_run("microcode write outside the image");
        assert (got_data[k] == ucode_img[idx])
          else value_error("fwd_data_o", got_data[k], ucode_img[idx]);
        n++;
      end
    end
    assert (n == NUM_TILES * UCODE_ELS)
      else value_error("microcode writes", 64'(n), 64'(NUM_TILES * UCODE_ELS));
  endtask

  task automatic run_back_pressure();
    lce_id_i     = 8'hc3;
    yumi_random  = 1'b1;
    hold_returns = 1'b0;
    max_delay    = MAX_DELAY;
    apply_reset();
    run_to_done();
  endtask

  task automatic check_completion();
    repeat (8) begin
      step_cycle();                              // done must hold with nothing more sent
    end
    assert (acc_count == NUM_CMDS) else value_error("accepts", 64'(acc_count), 64'(NUM_CMDS));
    assert (ret_count == NUM_CMDS) else value_error("returns", 64'(ret_count), 64'(NUM_CMDS));
  endtask

  task automatic run_credit_limit();
    lce_id_i     = 8'h17;
    yumi_random  = 1'b0;
    hold_returns = 1'b1;
    max_delay    = 2;
    apply_reset();
    repeat (4 * MAX_CREDITS) begin
      step_cycle();
    end
    assert (acc_count == MAX_CREDITS)
      else value_error("accepts with no returns", 64'(acc_count), 64'(MAX_CREDITS));
    assert (!fwd_v_o) else value_error("fwd_v_o", 64'(fwd_v_o), 64'd0);
    hold_returns = 1'b0;
    run_to_done();
  endtask

  initial begin
    reset_i      = 1'b1;
    lce_id_i     = '0;
    fwd_yumi_i   = 1'b0;
    rev_v_i      = 1'b0;
    lcg_state    = 2;
    timeout_cnt  = 0;
    cycle        = 0;
    cce_cycle    = 0;
    $readmemb("ucode.mem", ucode_img);
    build_expected();
    check_reset_state();
    run_full_order();
    check_ucode_contents();
    run_back_pressure();
    check_completion();
    run_credit_limit();
    $display("TESTS PASSED");
    $finish;
  end

endmodule

//--- ucode.mem
// one 64-bit coherence engine microcode word per line, binary, index 0 first
00010000_00000000_00000000_00000000_00000000_00000000_00000000_00000001
00010000_00000001_00000000_00000000_00000000_00000000_00000010_00000100
00100000_00000010_00000000_00000000_00000000_00000011_00000000_00001000
00110000_00000011_00000000_00000000_10000000_00000000_00000001_00010000
01000001_00000100_00000000_00000000_00000000_01000000_00000101_00100000
01010000_00000101_11000000_00000000_00000000_00000000_00000110_01000000
01100010_00000110_00000000_00001111_00000000_00000000_00000111_10000000
11110000_00000111_00000000_00000000_00000000_00000000_11111111_11111111

//--- filelist.f
hdl/cfg_loader_pkg.sv
hdl/cfg_loader_ctrl.sv
hdl/cfg_credit_counter.sv
hdl/cfg_ucode_rom.sv
hdl/cfg_cmd_former.sv
hdl/cfg_loader_top.sv
test/cfg_loader_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Builds the configuration loader testbench with Verilator and runs it.
# The exit status is the simulator's, nonzero when a check or the timeout fails.

if ! cd "$(dirname "$0")"; then
  echo "cannot enter the project directory"
  exit 1
fi

if ! verilator --binary --timing --assert -j 0 \
    --top-module cfg_loader_tb \
    -f filelist.f \
    -o sim_cfg_loader; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/sim_cfg_loader
status=$?
if [ "$status" -ne 0 ]; then
  echo "simulation exited with status $status"
fi
exit "$status"
